//--- design/hci_tcdm_pkg.sv
package hci_tcdm_pkg;

  // TCDM port geometry
  localparam int unsigned DW   = 64;
  localparam int unsigned BW   = 8;
  localparam int unsigned AW   = 12;
  localparam int unsigned UW   = 2;
  localparam int unsigned IW   = 4;
  localparam int unsigned BE_W = DW / BW;

  // word memory behind the port
  localparam int unsigned MEM_WORDS = 512;
  localparam int unsigned OFFS_W    = $clog2(DW / BW);
  localparam int unsigned IDX_W     = $clog2(MEM_WORDS);

  // error counters and their APB window
  localparam int unsigned CNT_W  = 16;
  localparam int unsigned APB_AW = 12;
  localparam int unsigned APB_DW = 32;

  // response opcode
  typedef enum logic {
    // request carried out
    OPC_OK  = 1'b0,
    // request dropped, metadata beyond repair
    OPC_ERR = 1'b1
  } hci_opc_e;

endpackage

//--- design/hci_ecc_pkg.sv
package hci_ecc_pkg;
  import hci_tcdm_pkg::*;

  // data is protected in independent chunks
  localparam int unsigned CHUNK_SIZE = 32;
  localparam int unsigned N_CHUNK    = DW / CHUNK_SIZE;
  localparam int unsigned MAX_ERR    = $clog2(N_CHUNK) + 1;

  // metadata words: {add, wen, be, user} and {opc, user}
  localparam int unsigned RQMETAW = AW + 1 + BE_W + UW;
  localparam int unsigned RSMETAW = 1 + UW;

  // SEC-DED check widths
  localparam int unsigned EW_DW     = $clog2(CHUNK_SIZE) + 2;
  localparam int unsigned EW_RQMETA = $clog2(RQMETAW) + 2;
  localparam int unsigned EW_RSMETA = $clog2(RSMETAW) + 2;
  localparam int unsigned EW        = N_CHUNK * EW_DW + EW_RQMETA;
  localparam int unsigned ZEROBITS  = EW_RQMETA - EW_RSMETA;

  localparam int unsigned N_ERR_CNT = 4;
  localparam int unsigned COL_W     = 8;

  // i-th odd-weight (>= 3) vector of prot_w bits, ascending
  function automatic logic [COL_W-1:0] hsiao_col(input int unsigned prot_w,
                                                 input int unsigned idx);
    int unsigned found;
    int unsigned wgt;
    logic [COL_W-1:0] col;
    found = 0;
    col   = '0;
    for (int unsigned v = 1; v < (1 << prot_w); v++) begin
      wgt = $countones(v);
      if ((wgt % 2 == 1) && (wgt >= 3)) begin
        if (found == idx) col = COL_W'(v);
        found++;
      end
    end
    return col;
  endfunction

endpackage

//--- design/hsiao_ecc_enc.sv
module hsiao_ecc_enc
  import hci_ecc_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth-1:0]           data_i,
  output logic [DataWidth+ProtWidth-1:0] code_o
);

  // parity check matrix, one column per data bit
  logic [DataWidth-1:0][ProtWidth-1:0] h_cols;
  logic [ProtWidth-1:0]                chk;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_cols
    assign h_cols[i] = ProtWidth'(hsiao_col(ProtWidth, i));
  end

  // each data bit toggles the check rows its column has set
  always_comb begin
    chk = '0;
    for (int i = 0; i < DataWidth; i++) begin
      chk = chk ^ (h_cols[i] & {ProtWidth{data_i[i]}});
    end
  end

  // checks sit above the data
  assign code_o = {chk, data_i};

endmodule

//--- design/hsiao_ecc_dec.sv
module hsiao_ecc_dec
  import hci_ecc_pkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth+ProtWidth-1:0] code_i,
  output logic [DataWidth-1:0]           data_o,
  output logic                           single_err_o,
  output logic                           multi_err_o
);

  logic [DataWidth-1:0][ProtWidth-1:0] h_cols;
  logic [DataWidth+ProtWidth-1:0]      recode;
  logic [ProtWidth-1:0]                syndrome;
  logic                                syn_odd;
  logic                                syn_nz;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_cols
    assign h_cols[i] = ProtWidth'(hsiao_col(ProtWidth, i));
  end

  // recompute checks from the received data
  hsiao_ecc_enc #(
    .DataWidth ( DataWidth ),
    .ProtWidth ( ProtWidth )
  ) i_recode (
    .data_i ( code_i[DataWidth-1:0] ),
    .code_o ( recode                )
  );

  assign syndrome = recode[DataWidth+:ProtWidth] ^ code_i[DataWidth+:ProtWidth];
  assign syn_odd  = ^syndrome;
  assign syn_nz   = |syndrome;

  // odd weight means one flipped bit, even nonzero means two
  assign single_err_o = syn_nz & syn_odd;
  assign multi_err_o  = syn_nz & ~syn_odd;

  // flip the data bit whose column equals the syndrome
  // a check bit error has a unit syndrome and matches no column
  always_comb begin
    for (int i = 0; i < DataWidth; i++) begin
      data_o[i] = code_i[i] ^ (syn_odd && (syndrome == h_cols[i]));
    end
  end

endmodule

//--- design/hci_ecc_dec.sv
module hci_ecc_dec
  import hci_tcdm_pkg::*;
  import hci_ecc_pkg::*;
(
  // core side
  input  logic               req_i,
  input  logic [AW-1:0]      add_i,
  input  logic               wen_i,
  input  logic [BE_W-1:0]    be_i,
  input  logic [DW-1:0]      data_i,
  input  logic [UW-1:0]      user_i,
  input  logic [IW-1:0]      id_i,
  input  logic [EW-1:0]      ecc_i,
  input  logic               r_ready_i,
  output logic               gnt_o,
  output logic               r_valid_o,
  output logic [DW-1:0]      r_data_o,
  output hci_opc_e           r_opc_o,
  output logic [UW-1:0]      r_user_o,
  output logic [IW-1:0]      r_id_o,
  output logic [EW-1:0]      r_ecc_o,
  // memory side
  output logic               mem_req_o,
  output logic [AW-1:0]      mem_add_o,
  output logic               mem_wen_o,
  output logic [BE_W-1:0]    mem_be_o,
  output logic [DW-1:0]      mem_data_o,
  output logic [UW-1:0]      mem_user_o,
  output logic [IW-1:0]      mem_id_o,
  output logic               mem_r_ready_o,
  input  logic               mem_gnt_i,
  input  logic               mem_r_valid_i,
  input  logic [DW-1:0]      mem_r_data_i,
  input  hci_opc_e           mem_r_opc_i,
  input  logic [UW-1:0]      mem_r_user_i,
  input  logic [IW-1:0]      mem_r_id_i,
  // per-request error counts
  output logic [MAX_ERR-1:0] data_single_err_o,
  output logic [MAX_ERR-1:0] data_multi_err_o,
  output logic               meta_single_err_o,
  output logic               meta_multi_err_o
);

  logic [N_CHUNK-1:0][EW_DW-1:0]            data_ecc;
  logic [N_CHUNK-1:0]                       chunk_single;
  logic [N_CHUNK-1:0]                       chunk_multi;
  logic [N_CHUNK-1:0][CHUNK_SIZE+EW_DW-1:0] r_data_code;
  logic [N_CHUNK-1:0][EW_DW-1:0]            r_data_ecc;
  logic [RSMETAW+EW_RSMETA-1:0]             r_meta_code;

  // request field: chunk checks above metadata checks
  assign data_ecc = ecc_i[EW-1:EW_RQMETA];

  for (genvar ii = 0; ii < N_CHUNK; ii++) begin : gen_chunk
    hsiao_ecc_dec #(
      .DataWidth ( CHUNK_SIZE ),
      .ProtWidth ( EW_DW      )
    ) i_data_dec (
      .code_i       ( {data_ecc[ii], data_i[ii*CHUNK_SIZE+:CHUNK_SIZE]} ),
      .data_o       ( mem_data_o[ii*CHUNK_SIZE+:CHUNK_SIZE]              ),
      .single_err_o ( chunk_single[ii]                                   ),
      .multi_err_o  ( chunk_multi[ii]                                    )
    );

    // response data re-encoded chunk by chunk
    hsiao_ecc_enc #(
      .DataWidth ( CHUNK_SIZE ),
      .ProtWidth ( EW_DW      )
    ) i_r_data_enc (
      .data_i ( mem_r_data_i[ii*CHUNK_SIZE+:CHUNK_SIZE] ),
      .code_o ( r_data_code[ii]                         )
    );

    assign r_data_ecc[ii] = r_data_code[ii][CHUNK_SIZE+:EW_DW];
  end

  hsiao_ecc_dec #(
    .DataWidth ( RQMETAW   ),
    .ProtWidth ( EW_RQMETA )
  ) i_meta_dec (
    .code_i       ( {ecc_i[EW_RQMETA-1:0], add_i, wen_i, be_i, user_i}   ),
    .data_o       ( {mem_add_o, mem_wen_o, mem_be_o, mem_user_o}          ),
    .single_err_o ( meta_single_err_o                                     ),
    .multi_err_o  ( meta_multi_err_o                                      )
  );

  hsiao_ecc_enc #(
    .DataWidth ( RSMETAW   ),
    .ProtWidth ( EW_RSMETA )
  ) i_r_meta_enc (
    .data_i ( {mem_r_opc_i, mem_r_user_i} ),
    .code_o ( r_meta_code                 )
  );

  // chunks hit by single and double errors
  always_comb begin
    data_single_err_o = '0;
    data_multi_err_o  = '0;
    for (int i = 0; i < N_CHUNK; i++) begin
      data_single_err_o = data_single_err_o + MAX_ERR'(chunk_single[i]);
      data_multi_err_o  = data_multi_err_o + MAX_ERR'(chunk_multi[i]);
    end
  end

  // handshakes and id pass straight through
  assign mem_req_o     = req_i;
  assign gnt_o         = mem_gnt_i;
  assign mem_id_o      = id_i;
  assign mem_r_ready_o = r_ready_i;
  assign r_valid_o     = mem_r_valid_i;
  assign r_data_o      = mem_r_data_i;
  assign r_opc_o       = mem_r_opc_i;
  assign r_user_o      = mem_r_user_i;
  assign r_id_o        = mem_r_id_i;

  assign r_ecc_o = {{ZEROBITS{1'b0}}, r_data_ecc, r_meta_code[RSMETAW+:EW_RSMETA]};

endmodule

//--- design/tcdm_mem_bank.sv
module tcdm_mem_bank
  import hci_tcdm_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_i,
  input  logic [AW-1:0]   add_i,
  input  logic            wen_i,
  input  logic [BE_W-1:0] be_i,
  input  logic [DW-1:0]   data_i,
  input  logic [UW-1:0]   user_i,
  input  logic [IW-1:0]   id_i,
  input  logic            drop_i,
  input  logic            r_ready_i,
  output logic            gnt_o,
  output logic            r_valid_o,
  output logic [DW-1:0]   r_data_o,
  output hci_opc_e        r_opc_o,
  output logic [UW-1:0]   r_user_o,
  output logic [IW-1:0]   r_id_o
);

  logic [DW-1:0]    mem_q [MEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             acc;
  logic             r_valid_q;

  assign word_idx = add_i[AW-1:OFFS_W];

  // one response slot, free again once it is consumed
  assign gnt_o = ~r_valid_q | r_ready_i;
  assign acc   = req_i & gnt_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (acc) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  // response payload, writes and dropped requests return zero
  always_ff @(posedge clk_i) begin
    if (acc) begin
      r_data_o <= (wen_i && !drop_i) ? mem_q[word_idx] : '0;
      r_opc_o  <= drop_i ? OPC_ERR : OPC_OK;
      r_user_o <= user_i;
      r_id_o   <= id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc && !wen_i && !drop_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) mem_q[word_idx][b*BW+:BW] <= data_i[b*BW+:BW];
      end
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

//--- design/ecc_err_regs.sv
module ecc_err_regs
  import hci_tcdm_pkg::*;
  import hci_ecc_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               acc_i,
  input  logic [MAX_ERR-1:0] data_single_err_i,
  input  logic [MAX_ERR-1:0] data_multi_err_i,
  input  logic               meta_single_err_i,
  input  logic               meta_multi_err_i,
  input  logic [APB_AW-1:0]  paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [APB_DW-1:0]  pwdata_i,
  output logic [APB_DW-1:0]  prdata_o,
  output logic               pready_o,
  output logic               pslverr_o
);

  logic [N_ERR_CNT-1:0][CNT_W-1:0] cnt_q;
  logic [N_ERR_CNT-1:0][CNT_W-1:0] inc;
  logic [1:0]                      sel_idx;
  logic                            addr_ok;
  logic                            apb_acc;
  logic                            apb_clr;

  function automatic logic [CNT_W-1:0] sat_add(input logic [CNT_W-1:0] a,
                                               input logic [CNT_W-1:0] b);
    logic [CNT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
  endfunction

  // counter order matches the register offsets
  assign inc[0] = CNT_W'(data_single_err_i);
  assign inc[1] = CNT_W'(data_multi_err_i);
  assign inc[2] = CNT_W'(meta_single_err_i);
  assign inc[3] = CNT_W'(meta_multi_err_i);

  // word aligned offsets 0x0 to 0xc only
  assign sel_idx = paddr_i[3:2];
  assign addr_ok = (paddr_i[APB_AW-1:4] == '0) && (paddr_i[1:0] == 2'b00);
  assign apb_acc = psel_i & penable_i;

  // any write clears the addressed counter regardless of the data
  assign apb_clr = apb_acc & pwrite_i & addr_ok;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int c = 0; c < N_ERR_CNT; c++) begin
        if (apb_clr && (sel_idx == 2'(c))) begin
          cnt_q[c] <= '0;
        end else if (acc_i) begin
          cnt_q[c] <= sat_add(cnt_q[c], inc[c]);
        end
      end
    end
  end

  // no wait states
  assign pready_o  = apb_acc;
  assign pslverr_o = apb_acc & ~addr_ok;
  assign prdata_o  = addr_ok ? APB_DW'(cnt_q[sel_idx]) : '0;

endmodule

//--- design/hci_ecc_mem_top.sv
module hci_ecc_mem_top
  import hci_tcdm_pkg::*;
  import hci_ecc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  // TCDM port
  input  logic              tcdm_req_i,
  input  logic [AW-1:0]     tcdm_add_i,
  input  logic              tcdm_wen_i,
  input  logic [BE_W-1:0]   tcdm_be_i,
  input  logic [DW-1:0]     tcdm_data_i,
  input  logic [UW-1:0]     tcdm_user_i,
  input  logic [IW-1:0]     tcdm_id_i,
  input  logic [EW-1:0]     tcdm_ecc_i,
  output logic              tcdm_gnt_o,
  output logic              tcdm_r_valid_o,
  output logic [DW-1:0]     tcdm_r_data_o,
  output hci_opc_e          tcdm_r_opc_o,
  output logic [UW-1:0]     tcdm_r_user_o,
  output logic [IW-1:0]     tcdm_r_id_o,
  output logic [EW-1:0]     tcdm_r_ecc_o,
  input  logic              tcdm_r_ready_i,
  // APB to the error counters
  input  logic [APB_AW-1:0] apb_paddr_i,
  input  logic              apb_psel_i,
  input  logic              apb_penable_i,
  input  logic              apb_pwrite_i,
  input  logic [APB_DW-1:0] apb_pwdata_i,
  output logic [APB_DW-1:0] apb_prdata_o,
  output logic              apb_pready_o,
  output logic              apb_pslverr_o
);

  logic               mem_req;
  logic [AW-1:0]      mem_add;
  logic               mem_wen;
  logic [BE_W-1:0]    mem_be;
  logic [DW-1:0]      mem_data;
  logic [UW-1:0]      mem_user;
  logic [IW-1:0]      mem_id;
  logic               mem_r_ready;
  logic               mem_gnt;
  logic               mem_r_valid;
  logic [DW-1:0]      mem_r_data;
  hci_opc_e           mem_r_opc;
  logic [UW-1:0]      mem_r_user;
  logic [IW-1:0]      mem_r_id;
  logic [MAX_ERR-1:0] data_single_err;
  logic [MAX_ERR-1:0] data_multi_err;
  logic               meta_single_err;
  logic               meta_multi_err;
  logic               req_acc;

  // counts belong to the request accepted this cycle
  assign req_acc = tcdm_req_i & tcdm_gnt_o;

  hci_ecc_dec i_ecc_dec (
    .req_i             ( tcdm_req_i      ),
    .add_i             ( tcdm_add_i      ),
    .wen_i             ( tcdm_wen_i      ),
    .be_i              ( tcdm_be_i       ),
    .data_i            ( tcdm_data_i     ),
    .user_i            ( tcdm_user_i     ),
    .id_i              ( tcdm_id_i       ),
    .ecc_i             ( tcdm_ecc_i      ),
    .r_ready_i         ( tcdm_r_ready_i  ),
    .gnt_o             ( tcdm_gnt_o      ),
    .r_valid_o         ( tcdm_r_valid_o  ),
    .r_data_o          ( tcdm_r_data_o   ),
    .r_opc_o           ( tcdm_r_opc_o    ),
    .r_user_o          ( tcdm_r_user_o   ),
    .r_id_o            ( tcdm_r_id_o     ),
    .r_ecc_o           ( tcdm_r_ecc_o    ),
    .mem_req_o         ( mem_req         ),
    .mem_add_o         ( mem_add         ),
    .mem_wen_o         ( mem_wen         ),
    .mem_be_o          ( mem_be          ),
    .mem_data_o        ( mem_data        ),
    .mem_user_o        ( mem_user        ),
    .mem_id_o          ( mem_id          ),
    .mem_r_ready_o     ( mem_r_ready     ),
    .mem_gnt_i         ( mem_gnt         ),
    .mem_r_valid_i     ( mem_r_valid     ),
    .mem_r_data_i      ( mem_r_data      ),
    .mem_r_opc_i       ( mem_r_opc       ),
    .mem_r_user_i      ( mem_r_user      ),
    .mem_r_id_i        ( mem_r_id        ),
    .data_single_err_o ( data_single_err ),
    .data_multi_err_o  ( data_multi_err  ),
    .meta_single_err_o ( meta_single_err ),
    .meta_multi_err_o  ( meta_multi_err  )
  );

  // uncorrectable metadata turns the request into a dropped one
  tcdm_mem_bank i_mem_bank (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .req_i     ( mem_req        ),
    .add_i     ( mem_add        ),
    .wen_i     ( mem_wen        ),
    .be_i      ( mem_be         ),
    .data_i    ( mem_data       ),
    .user_i    ( mem_user       ),
    .id_i      ( mem_id         ),
    .drop_i    ( meta_multi_err ),
    .r_ready_i ( mem_r_ready    ),
    .gnt_o     ( mem_gnt        ),
    .r_valid_o ( mem_r_valid    ),
    .r_data_o  ( mem_r_data     ),
    .r_opc_o   ( mem_r_opc      ),
    .r_user_o  ( mem_r_user     ),
    .r_id_o    ( mem_r_id       )
  );

  ecc_err_regs i_err_regs (
    .clk_i             ( clk_i           ),
    .rst_n_i           ( rst_n_i         ),
    .acc_i             ( req_acc         ),
    .data_single_err_i ( data_single_err ),
    .data_multi_err_i  ( data_multi_err  ),
    .meta_single_err_i ( meta_single_err ),
    .meta_multi_err_i  ( meta_multi_err  ),
    .paddr_i           ( apb_paddr_i     ),
    .psel_i            ( apb_psel_i      ),
    .penable_i         ( apb_penable_i   ),
    .pwrite_i          ( apb_pwrite_i    ),
    .pwdata_i          ( apb_pwdata_i    ),
    .prdata_o          ( apb_prdata_o    ),
    .pready_o          ( apb_pready_o    ),
    .pslverr_o         ( apb_pslverr_o   )
  );

endmodule

//--- verification/tb_ecc_model.svh
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// idx-th vector of pw bits with odd weight of at least three, ascending
function automatic logic [7:0] hsiao_column(input int pw, input int idx);
  int n;
  int w;
  n = 0;
  for (int v = 1; v < (1 << pw); v++) begin
    w = $countones(v);
    if ((w % 2 == 1) && (w >= 3)) begin
      if (n == idx) return 8'(v);
      n++;
    end
  end
  return 8'h00;
endfunction

// parity of the data bits that have each row set
function automatic logic [7:0] check_bits(input logic [63:0] data, input int dw, input int pw);
  logic [7:0] chk;
  chk = '0;
  for (int i = 0; i < dw; i++) begin
    if (data[i]) chk = chk ^ hsiao_column(pw, i);
  end
  return chk;
endfunction

// status 0 clean, 1 corrected single, 2 uncorrectable
function automatic logic [63:0] fix_word(input logic [63:0] data, input logic [7:0] chk,
                                         input int dw, input int pw, output int status);
  logic [7:0]  syn;
  logic [63:0] fixed;
  syn    = check_bits(data, dw, pw) ^ chk;
  fixed  = data;
  status = 0;
  if (syn != 8'h00) begin
    if ($countones(syn) % 2 == 1) begin
      status = 1;
      // unit syndrome is a check bit and matches no data column
      for (int i = 0; i < dw; i++) begin
        if (hsiao_column(pw, i) == syn) fixed[i] = ~fixed[i];
      end
    end else begin
      status = 2;
    end
  end
  return fixed;
endfunction

function automatic logic [EW-1:0] req_ecc_field(input logic [DW-1:0] data,
                                               input logic [RQMETAW-1:0] meta);
  logic [7:0] c_lo;
  logic [7:0] c_hi;
  logic [7:0] c_meta;
  c_lo   = check_bits(64'(data[CHUNK_SIZE-1:0]), CHUNK_SIZE, EW_DW);
  c_hi   = check_bits(64'(data[DW-1:CHUNK_SIZE]), CHUNK_SIZE, EW_DW);
  c_meta = check_bits(64'(meta), RQMETAW, EW_RQMETA);
  return {c_hi[EW_DW-1:0], c_lo[EW_DW-1:0], c_meta[EW_RQMETA-1:0]};
endfunction

function automatic logic [EW-1:0] rsp_ecc_field(input logic [DW-1:0] data, input logic opc,
                                               input logic [UW-1:0] user);
  logic [7:0] c_lo;
  logic [7:0] c_hi;
  logic [7:0] c_meta;
  c_lo   = check_bits(64'(data[CHUNK_SIZE-1:0]), CHUNK_SIZE, EW_DW);
  c_hi   = check_bits(64'(data[DW-1:CHUNK_SIZE]), CHUNK_SIZE, EW_DW);
  c_meta = check_bits(64'({opc, user}), RSMETAW, EW_RSMETA);
  return {{ZEROBITS{1'b0}}, c_hi[EW_DW-1:0], c_lo[EW_DW-1:0], c_meta[EW_RSMETA-1:0]};
endfunction

`endif

//--- verification/tb_hci_ecc_mem_top.sv
module tb_hci_ecc_mem_top
  import hci_tcdm_pkg::*;
  import hci_ecc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [DW-1:0] data;
    logic          opc;
    logic [UW-1:0] user;
    logic [IW-1:0] id;
    logic [EW-1:0] ecc;
  } rsp_t;

  logic              clk_i;
  logic              rst_n_i;
  logic              tcdm_req_i;
  logic [AW-1:0]     tcdm_add_i;
  logic              tcdm_wen_i;
  logic [BE_W-1:0]   tcdm_be_i;
  logic [DW-1:0]     tcdm_data_i;
  logic [UW-1:0]     tcdm_user_i;
  logic [IW-1:0]     tcdm_id_i;
  logic [EW-1:0]     tcdm_ecc_i;
  logic              tcdm_gnt_o;
  logic              tcdm_r_valid_o;
  logic [DW-1:0]     tcdm_r_data_o;
  hci_opc_e          tcdm_r_opc_o;
  logic [UW-1:0]     tcdm_r_user_o;
  logic [IW-1:0]     tcdm_r_id_o;
  logic [EW-1:0]     tcdm_r_ecc_o;
  logic              tcdm_r_ready_i;
  logic [APB_AW-1:0] apb_paddr_i;
  logic              apb_psel_i;
  logic              apb_penable_i;
  logic              apb_pwrite_i;
  logic [APB_DW-1:0] apb_pwdata_i;
  logic [APB_DW-1:0] apb_prdata_o;
  logic              apb_pready_o;
  logic              apb_pslverr_o;

  integer        seed;
  logic          stall_on;
  logic [IW-1:0] next_id;
  string         test_name;
  rsp_t          expq[$];
  logic [DW-1:0] shadow[MEM_WORDS];
  int            cnt_exp[4];

  `include "tb_ecc_model.svh"

  hci_ecc_mem_top hci_ecc_mem_top_inst (.*);

  always begin
    #5 clk_i = ~clk_i;
  end

  // ready is held high unless stalls are enabled
  always @(negedge clk_i) begin
    tcdm_r_ready_i = stall_on ? (rand_below(3) != 0) : 1'b1;
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  function automatic logic [DW-1:0] rand64();
    logic [DW-1:0] v;
    v = {$random(seed), $random(seed)};
    return v;
  endfunction

  // models one accepted request on shadow memory and counts and returns its response
  function automatic rsp_t model_request(input logic [RQMETAW-1:0] meta_in,
                                         input logic [DW-1:0] data, input logic [IW-1:0] id,
                                         input logic [EW-1:0] ecc);
    rsp_t             r;
    logic [63:0]      meta;
    logic [63:0]      lo;
    logic [63:0]      hi;
    logic [AW-1:0]    add;
    logic [BE_W-1:0]  be;
    logic [IDX_W-1:0] idx;
    logic [DW-1:0]    wdata;
    int               s_meta;
    int               s_lo;
    int               s_hi;
    meta = fix_word(64'(meta_in), 8'(ecc[EW_RQMETA-1:0]), RQMETAW, EW_RQMETA, s_meta);
    lo = fix_word(64'(data[CHUNK_SIZE-1:0]), 8'(ecc[EW_RQMETA+:EW_DW]), CHUNK_SIZE, EW_DW,
                  s_lo);
    hi = fix_word(64'(data[DW-1:CHUNK_SIZE]), 8'(ecc[EW_RQMETA+EW_DW+:EW_DW]), CHUNK_SIZE,
                  EW_DW, s_hi);
    cnt_exp[0] = cnt_exp[0] + (s_lo == 1) + (s_hi == 1);
    cnt_exp[1] = cnt_exp[1] + (s_lo == 2) + (s_hi == 2);
    cnt_exp[2] = cnt_exp[2] + (s_meta == 1);
    cnt_exp[3] = cnt_exp[3] + (s_meta == 2);
    add    = meta[UW+BE_W+1+:AW];
    be     = meta[UW+:BE_W];
    idx    = add[AW-1:OFFS_W];
    r.user = meta[UW-1:0];
    r.id   = id;
    r.opc  = OPC_OK;
    r.data = '0;
    if (s_meta == 2) begin
      r.opc = OPC_ERR;
    end else if (meta[UW+BE_W]) begin
      r.data = shadow[idx];
    end else begin
      wdata = {hi[CHUNK_SIZE-1:0], lo[CHUNK_SIZE-1:0]};
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) shadow[idx][b*BW+:BW] = wdata[b*BW+:BW];
      end
    end
    r.ecc = rsp_ecc_field(r.data, r.opc, r.user);
    return r;
  endfunction

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // called at a falling edge and returns at one with req low
  task automatic send(input logic [AW-1:0] add, input logic wen, input logic [BE_W-1:0] be,
                      input logic [DW-1:0] data, input logic [UW-1:0] user,
                      input logic [DW-1:0] data_flip, input logic [EW-1:0] ecc_flip,
                      input logic [RQMETAW-1:0] meta_flip);
    logic [RQMETAW-1:0] meta;
    int                 waited;
    meta = {add, wen, be, user} ^ meta_flip;
    tcdm_req_i = 1'b1;
    {tcdm_add_i, tcdm_wen_i, tcdm_be_i, tcdm_user_i} = meta;
    tcdm_data_i = data ^ data_flip;
    tcdm_id_i   = next_id;
    tcdm_ecc_i  = req_ecc_field(data, {add, wen, be, user}) ^ ecc_flip;
    waited = 0;
    @(posedge clk_i);
    while (!tcdm_gnt_o) begin
      waited++;
      if (waited > 200) begin
        $display("timeout: request with id %0d was never granted", next_id);
        stop_on_error();
      end
      @(posedge clk_i);
    end
    expq.push_back(model_request(meta, tcdm_data_i, next_id, tcdm_ecc_i));
    next_id = next_id + 1'b1;
    @(negedge clk_i);
    tcdm_req_i = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (expq.size() != 0) begin
      waited++;
      if (waited > 1000) begin
        $display("timeout: %0d responses never arrived", expq.size());
        stop_on_error();
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  task automatic apb_transfer(input logic [APB_AW-1:0] addr, input logic write,
                              output logic [APB_DW-1:0] rdata, output logic err);
    int waited;
    apb_paddr_i   = addr;
    apb_psel_i    = 1'b1;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = write;
    apb_pwdata_i  = write ? APB_DW'($random(seed)) : '0;
    @(negedge clk_i);
    apb_penable_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!apb_pready_o) begin
      waited++;
      if (waited > 20) begin
        $display("timeout: APB slave never raised pready");
        stop_on_error();
      end
      @(posedge clk_i);
    end
    rdata = apb_prdata_o;
    err   = apb_pslverr_o;
    @(negedge clk_i);
    apb_psel_i    = 1'b0;
    apb_penable_i = 1'b0;
    apb_pwrite_i  = 1'b0;
  endtask

  task automatic read_counter(input int idx);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_transfer(APB_AW'(idx * 4), 1'b0, rd, err);
    compare("pslverr", 0, err);
    compare($sformatf("counter %0d", idx), cnt_exp[idx], rd);
  endtask

  task automatic clear_counter(input int idx);
    logic [APB_DW-1:0] rd;
    logic              err;
    apb_transfer(APB_AW'(idx * 4), 1'b1, rd, err);
    compare("pslverr", 0, err);
    cnt_exp[idx] = 0;
  endtask

  // every consumed response against the oldest outstanding request
  always @(posedge clk_i) begin : check_responses
    rsp_t e;
    if (rst_n_i && tcdm_r_valid_o && tcdm_r_ready_i) begin
      if (expq.size() == 0) begin
        $display("a response arrived with no request outstanding");
        stop_on_error();
      end else begin
        e = expq.pop_front();
        compare("r_id", e.id, tcdm_r_id_o);
        compare("r_data", e.data, tcdm_r_data_o);
        compare("r_opc", e.opc, tcdm_r_opc_o);
        compare("r_user", e.user, tcdm_r_user_o);
        compare("r_ecc", e.ecc, tcdm_r_ecc_o);
      end
    end
  end

  initial begin : run_test
    logic [APB_DW-1:0]  rd;
    logic               err;
    logic [AW-1:0]      add;
    logic [DW-1:0]      d;
    logic [DW-1:0]      df;
    logic [EW-1:0]      ef;
    logic [RQMETAW-1:0] mf;
    int                 a;
    int                 b;
    seed           = 83;
    stall_on       = 1'b0;
    next_id        = '0;
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    tcdm_req_i     = 1'b0;
    tcdm_add_i     = '0;
    tcdm_wen_i     = 1'b0;
    tcdm_be_i      = '0;
    tcdm_data_i    = '0;
    tcdm_user_i    = '0;
    tcdm_id_i      = '0;
    tcdm_ecc_i     = '0;
    tcdm_r_ready_i = 1'b1;
    apb_paddr_i    = '0;
    apb_psel_i     = 1'b0;
    apb_penable_i  = 1'b0;
    apb_pwrite_i   = 1'b0;
    apb_pwdata_i   = '0;
    for (int c = 0; c < 4; c++) cnt_exp[c] = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    test_name = "reset";
    compare("r_valid", 0, tcdm_r_valid_o);
    compare("gnt", 1, tcdm_gnt_o);
    compare("pslverr", 0, apb_pslverr_o);
    rst_n_i = 1'b1;

    // fill pattern from the whole word index
    test_name = "preload";
    for (int w = 0; w < MEM_WORDS; w++) begin
      d = {32'(w) * 32'h9e37_79b9, ~32'(w) ^ 32'h00c0_ffee};
      send(AW'(w << OFFS_W), 1'b0, '1, d, UW'(w), '0, '0, '0);
    end

    test_name = "clean";
    for (int i = 0; i < 200; i++) begin
      add = AW'(rand_below(1 << AW));
      send(add, 1'(rand_below(2)), BE_W'(rand_below(256)), rand64(), UW'(rand_below(4)),
           '0, '0, '0);
    end
    wait_drained();
    for (int c = 0; c < 4; c++) read_counter(c);

    // chunk 0, chunk 1, then both
    test_name = "data_single";
    for (int i = 0; i < 30; i++) begin
      add = AW'(rand_below(1 << AW));
      d   = rand64();
      df  = '0;
      ef  = '0;
      for (int k = 0; k < N_CHUNK; k++) begin
        if ((i % 3 == k) || (i % 3 == 2)) begin
          a = rand_below(CHUNK_SIZE + EW_DW);
          if (a < CHUNK_SIZE) df[k*CHUNK_SIZE+a] = 1'b1;
          else ef[EW_RQMETA+k*EW_DW+a-CHUNK_SIZE] = 1'b1;
        end
      end
      send(add, 1'b0, '1, d, 2'b01, df, ef, '0);
      send(add, 1'b1, '0, '0, 2'b01, '0, '0, '0);
    end
    wait_drained();
    read_counter(0);
    read_counter(1);

    test_name = "data_double";
    for (int i = 0; i < 16; i++) begin
      add = AW'(rand_below(1 << AW));
      d   = rand64();
      df  = '0;
      a   = rand_below(CHUNK_SIZE);
      b   = (a + 1 + rand_below(CHUNK_SIZE - 1)) % CHUNK_SIZE;
      df[(i%2)*CHUNK_SIZE+a] = 1'b1;
      df[(i%2)*CHUNK_SIZE+b] = 1'b1;
      send(add, 1'b0, '1, d, 2'b10, df, '0, '0);
      send(add, 1'b1, '0, '0, 2'b10, '0, '0, '0);
    end
    wait_drained();
    read_counter(0);
    read_counter(1);

    // flips in address, byte enables or check bits
    test_name = "meta_single";
    for (int i = 0; i < 24; i++) begin
      add = AW'(rand_below(1 << AW));
      mf  = '0;
      ef  = '0;
      a   = rand_below(AW + BE_W + EW_RQMETA);
      if (a < AW) mf[UW+BE_W+1+a] = 1'b1;
      else if (a < AW + BE_W) mf[UW+a-AW] = 1'b1;
      else ef[a-AW-BE_W] = 1'b1;
      send(add, 1'b0, BE_W'(rand_below(256)), rand64(), 2'b11, '0, ef, mf);
      send(add, 1'b1, '0, '0, 2'b11, '0, '0, '0);
    end

    test_name = "meta_double";
    for (int i = 0; i < 12; i++) begin
      add = AW'(rand_below(1 << AW));
      mf  = '0;
      a   = rand_below(AW);
      b   = (a + 1 + rand_below(AW - 1)) % AW;
      mf[UW+BE_W+1+a] = 1'b1;
      mf[UW+BE_W+1+b] = 1'b1;
      send(add, 1'(i % 2), '1, rand64(), 2'b00, '0, '0, mf);
      // read back where the corrupted address points
      add = add ^ mf[UW+BE_W+1+:AW];
      send(add, 1'b1, '0, '0, 2'b00, '0, '0, '0);
    end
    wait_drained();
    for (int c = 0; c < 4; c++) read_counter(c);

    test_name = "apb";
    clear_counter(1);
    for (int c = 0; c < 4; c++) read_counter(c);
    clear_counter(0);
    clear_counter(2);
    clear_counter(3);
    for (int c = 0; c < 4; c++) read_counter(c);
    apb_transfer(APB_AW'('h10), 1'b0, rd, err);
    compare("pslverr at 0x10", 1, err);
    compare("prdata at 0x10", 0, rd);

    test_name = "stall";
    stall_on = 1'b1;
    for (int i = 0; i < 300; i++) begin
      add = AW'(rand_below(1 << AW));
      send(add, 1'(rand_below(2)), BE_W'(rand_below(256)), rand64(), UW'(rand_below(4)),
           '0, '0, '0);
    end
    wait_drained();
    stall_on = 1'b0;
    for (int c = 0; c < 4; c++) read_counter(c);

    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verification
design/hci_tcdm_pkg.sv
design/hci_ecc_pkg.sv
design/hsiao_ecc_enc.sv
design/hsiao_ecc_dec.sv
design/hci_ecc_dec.sv
design/tcdm_mem_bank.sv
design/ecc_err_regs.sv
design/hci_ecc_mem_top.sv
verification/tb_hci_ecc_mem_top.sv

//--- Bender.yml
package:
  name: hci_ecc_mem

sources:
  - design/hci_tcdm_pkg.sv
  - design/hci_ecc_pkg.sv
  - design/hsiao_ecc_enc.sv
  - design/hsiao_ecc_dec.sv
  - design/hci_ecc_dec.sv
  - design/tcdm_mem_bank.sv
  - design/ecc_err_regs.sv
  - design/hci_ecc_mem_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_hci_ecc_mem_top.sv
